/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= cube_update_tb
RTL_TOP   ?= cube_update
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv sim/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/color_census.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cube_config.svh"

module color_census
    import cube_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        census_start,
    input  cube_state_u cube_in,
    output logic        census_done,
    output logic        census_ok
);

    localparam int CNT_W  = $clog2(`CUBE_STICKERS + 1);
    localparam int COLORS = int'(color_yellow) + 1;

    cube_state_u      shift_reg;
    logic [CNT_W-1:0] sticker_idx;
    logic [CNT_W-1:0] color_cnt [COLORS];
    logic             active;
    color_t           cur_sticker;

    // the start cycle already counts sticker 0 straight from the input
    assign cur_sticker = census_start ? cube_in.stickers[0] : shift_reg.stickers[0];

    always_ff @(posedge clock) begin
        if (census_start) begin
            shift_reg.flat <= cube_in.flat << `CUBE_STICKER_W;
        end else if (active) begin
            shift_reg.flat <= shift_reg.flat << `CUBE_STICKER_W;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            active      <= 1'b0;
            census_done <= 1'b0;
            sticker_idx <= '0;
            for (int c = 0; c < COLORS; c++) begin
                color_cnt[c] <= '0;
            end
        end else begin
            census_done <= 1'b0;
            if (census_start || active) begin
                for (int c = 0; c < COLORS; c++) begin
                    color_cnt[c] <= (census_start ? '0 : color_cnt[c]) +
                                    CNT_W'(cur_sticker == c);
                end
            end
            if (census_start) begin
                active      <= 1'b1;
                sticker_idx <= CNT_W'(1);
            end else if (active) begin
                sticker_idx <= sticker_idx + CNT_W'(1);
                if (sticker_idx == CNT_W'(`CUBE_STICKERS - 1)) begin
                    active      <= 1'b0;
                    census_done <= 1'b1;
                end
            end
        end
    end

    // counters are final in the done cycle
    // a code of 6 or 7 is counted by no colour, so some colour falls short
    always_comb begin
        census_ok = 1'b1;
        for (int c = 0; c < COLORS; c++) begin
            if (color_cnt[c] != CNT_W'(`CUBE_COLOR_QUOTA)) begin
                census_ok = 1'b0;
            end
        end
    end

    assert property (@(posedge clock) disable iff (rst)
        census_start |-> ##54 census_done);

endmodule

`default_nettype wire

/* logic/cube_config.svh */
`ifndef CUBE_CONFIG_SVH
`define CUBE_CONFIG_SVH

// one sticker holds a colour code
`define CUBE_STICKER_W 3

// six faces of nine
`define CUBE_STICKERS 54

// slots in one move word, first move in the top nibble
`define CUBE_MOVE_SLOTS 50

// bits per move code
`define CUBE_MOVE_W 4

// stickers each colour must show on a sound cube
`define CUBE_COLOR_QUOTA 9

`endif

/* logic/cube_pkg.sv */
`default_nettype none

`include "cube_config.svh"

package cube_pkg;

    // quarter turns, primed codes follow their plain turn
    typedef enum logic [`CUBE_MOVE_W-1:0] {
        move_r    = 4'd2,
        move_ri   = 4'd3,
        move_u    = 4'd4,
        move_ui   = 4'd5,
        move_f    = 4'd6,
        move_fi   = 4'd7,
        move_l    = 4'd8,
        move_li   = 4'd9,
        move_b    = 4'd10,
        move_bi   = 4'd11,
        move_d    = 4'd12,
        move_di   = 4'd13,
        move_null = 4'd15
    } move_t;

    // codes 6 and 7 are never a legal colour
    typedef enum logic [`CUBE_STICKER_W-1:0] {
        color_white  = 3'd0,
        color_orange = 3'd1,
        color_green  = 3'd2,
        color_red    = 3'd3,
        color_blue   = 3'd4,
        color_yellow = 3'd5
    } color_t;

    // sticker 0 sits in the top bits of flat
    typedef union packed {
        logic [`CUBE_STICKERS*`CUBE_STICKER_W-1:0] flat;
        color_t [0:`CUBE_STICKERS-1]                stickers;
    } cube_state_u;

    // slot 0 is the first move
    typedef move_t [0:`CUBE_MOVE_SLOTS-1] move_list_t;

endpackage

`default_nettype wire

/* logic/cube_turn.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cube_config.svh"

module cube_turn
    import cube_pkg::*;
(
    input  cube_state_u cur_state,
    input  move_t       cur_move,
    output cube_state_u turned_state
);

    localparam int LAST = `CUBE_STICKERS - 1;

    // cycle tables number stickers from the lsb end of the flat word
    // each row a b c d moves the sticker at a to b, b to c, c to d, d to a
    // rows are two corner cycles, one edge cycle and two face cycles

    localparam logic [0:4][0:3][5:0] R_CYC = '{
        '{10,  2, 18, 22},
        '{11,  3, 19, 23},
        '{32, 27, 42, 47},
        '{13, 12, 15, 14},
        '{37, 36, 39, 38}
    };

    localparam logic [0:4][0:3][5:0] U_CYC = '{
        '{13,  8,  7, 18},
        '{12, 11,  6, 17},
        '{36, 35, 30, 43},
        '{ 1,  0,  3,  2},
        '{26, 25, 24, 27}
    };

    localparam logic [0:4][0:3][5:0] F_CYC = '{
        '{ 1, 13, 23,  5},
        '{ 2, 14, 20,  6},
        '{29, 26, 37, 46},
        '{ 8, 11, 10,  9},
        '{34, 35, 32, 33}
    };

    localparam logic [0:4][0:3][5:0] L_CYC = '{
        '{16,  0,  8, 20},
        '{17,  1,  9, 21},
        '{25, 34, 45, 40},
        '{ 4,  7,  6,  5},
        '{28, 31, 30, 29}
    };

    // back face rows are full four-cycles
    localparam logic [0:4][0:3][5:0] B_CYC = '{
        '{12,  0,  4, 22},
        '{15,  3,  7, 21},
        '{39, 24, 31, 44},
        '{19, 18, 17, 16},
        '{41, 42, 43, 40}
    };

    localparam logic [0:4][0:3][5:0] D_CYC = '{
        '{ 4,  9, 14, 19},
        '{ 5, 10, 15, 16},
        '{28, 33, 38, 41},
        '{21, 20, 23, 22},
        '{45, 46, 47, 44}
    };

    // inv runs every cycle backwards, so a primed turn undoes its plain turn
    function automatic cube_state_u turn_face(
        input cube_state_u               src,
        input logic [0:4][0:3][5:0]      cyc,
        input logic                      inv
    );
        cube_state_u dst;
        dst = src;
        for (int c = 0; c < 5; c++) begin
            for (int p = 0; p < 4; p++) begin
                if (inv) begin
                    dst.stickers[LAST - cyc[c][p]] =
                        src.stickers[LAST - cyc[c][(p + 1) % 4]];
                end else begin
                    dst.stickers[LAST - cyc[c][(p + 1) % 4]] =
                        src.stickers[LAST - cyc[c][p]];
                end
            end
        end
        return dst;
    endfunction

    always_comb begin
        // null and unknown codes keep the cube as it is
        turned_state = cur_state;
        case (cur_move)
            move_r:  turned_state = turn_face(cur_state, R_CYC, 1'b0);
            move_ri: turned_state = turn_face(cur_state, R_CYC, 1'b1);
            move_u:  turned_state = turn_face(cur_state, U_CYC, 1'b0);
            move_ui: turned_state = turn_face(cur_state, U_CYC, 1'b1);
            move_f:  turned_state = turn_face(cur_state, F_CYC, 1'b0);
            move_fi: turned_state = turn_face(cur_state, F_CYC, 1'b1);
            move_l:  turned_state = turn_face(cur_state, L_CYC, 1'b0);
            move_li: turned_state = turn_face(cur_state, L_CYC, 1'b1);
            move_b:  turned_state = turn_face(cur_state, B_CYC, 1'b0);
            move_bi: turned_state = turn_face(cur_state, B_CYC, 1'b1);
            move_d:  turned_state = turn_face(cur_state, D_CYC, 1'b0);
            move_di: turned_state = turn_face(cur_state, D_CYC, 1'b1);
            default: turned_state = cur_state;
        endcase
    end

endmodule

`default_nettype wire

/* logic/cube_update.sv */
`default_nettype none
`timescale 1ns/100ps

module cube_update
    import cube_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        start,
    input  move_list_t  moves_in,
    input  cube_state_u cube_in,
    output logic        busy,
    output logic        done,
    output logic        illegal,
    output move_t       bad_move,
    output cube_state_u cube_out
);

    cube_state_u cur_state;
    cube_state_u turned_state;
    move_t       cur_move;
    logic        census_start;
    logic        census_done;
    logic        census_ok;

    move_sequencer u_sequencer (
        .clock        (clock),
        .rst          (rst),
        .start        (start),
        .moves_in     (moves_in),
        .cube_in      (cube_in),
        .turned_state (turned_state),
        .census_done  (census_done),
        .census_ok    (census_ok),
        .cur_state    (cur_state),
        .cur_move     (cur_move),
        .census_start (census_start),
        .busy         (busy),
        .done         (done),
        .illegal      (illegal),
        .bad_move     (bad_move),
        .cube_out     (cube_out)
    );

    cube_turn u_turn (
        .cur_state    (cur_state),
        .cur_move     (cur_move),
        .turned_state (turned_state)
    );

    // census reads the register the sequencer just loaded
    color_census u_census (
        .clock        (clock),
        .rst          (rst),
        .census_start (census_start),
        .cube_in      (cur_state),
        .census_done  (census_done),
        .census_ok    (census_ok)
    );

endmodule

`default_nettype wire

/* logic/move_sequencer.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cube_config.svh"

module move_sequencer
    import cube_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        start,
    input  move_list_t  moves_in,
    input  cube_state_u cube_in,
    input  cube_state_u turned_state,
    input  logic        census_done,
    input  logic        census_ok,
    output cube_state_u cur_state,
    output move_t       cur_move,
    output logic        census_start,
    output logic        busy,
    output logic        done,
    output logic        illegal,
    output move_t       bad_move,
    output cube_state_u cube_out
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_TURN   = 2'd1;
    localparam logic [1:0] ST_CENSUS = 2'd2;

    logic [1:0]  state;
    logic [5:0]  slot_cnt;
    cube_state_u cube_reg;
    move_list_t  move_list;

    wire last_slot = (slot_cnt == 6'(`CUBE_MOVE_SLOTS - 1));

    assign busy      = (state != ST_IDLE);
    assign cur_state = cube_reg;
    assign cur_move  = move_list[0];

    always_ff @(posedge clock) begin
        if (rst) begin
            state        <= ST_IDLE;
            slot_cnt     <= '0;
            census_start <= 1'b0;
            done         <= 1'b0;
            illegal      <= 1'b0;
            bad_move     <= move_null;
            cube_out     <= '0;
        end else begin
            census_start <= 1'b0;
            done         <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        slot_cnt <= '0;
                        illegal  <= 1'b0;
                        bad_move <= move_null;
                        state    <= ST_TURN;
                    end
                end
                ST_TURN: begin
                    census_start <= 1'b1;
                    state        <= ST_CENSUS;
                end
                ST_CENSUS: begin
                    if (census_done) begin
                        // only the first failing slot is kept
                        if (!census_ok && !illegal) begin
                            illegal  <= 1'b1;
                            bad_move <= move_list[0];
                        end
                        slot_cnt <= slot_cnt + 6'd1;
                        if (last_slot) begin
                            done     <= 1'b1;
                            cube_out <= cube_reg;
                            state    <= ST_IDLE;
                        end else begin
                            state <= ST_TURN;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // cube and move list
    always_ff @(posedge clock) begin
        if (state == ST_IDLE && start) begin
            cube_reg  <= cube_in;
            move_list <= moves_in;
        end else if (state == ST_TURN) begin
            cube_reg <= turned_state;
        end else if (state == ST_CENSUS && census_done) begin
            move_list <= move_list_t'({move_list[1:`CUBE_MOVE_SLOTS-1], move_null});
        end
    end

    // a new census waits for the running one to report
    assert property (@(posedge clock) disable iff (rst)
        census_start |=> (!census_start throughout census_done [-> 1]));

endmodule

`default_nettype wire

/* sim/cube_tb_cases.svh */
// columns are name, cube source, move pattern, pattern turn, busy restart,
// result kind and expected bad_move

typedef enum int {SRC_RANDOM, SRC_RECOLOR, SRC_BAD_CODE, SRC_PREVIOUS} cube_src_e;
typedef enum int {PAT_NULL, PAT_PAIR, PAT_QUAD, PAT_RANDOM} pattern_e;
typedef enum int {RES_SAME, RES_ILLEGAL} result_e;

typedef struct {
    string     name;
    cube_src_e src;
    pattern_e  pat;
    move_t     turn;
    logic      restart;
    result_e   kind;
    move_t     bad;
} case_t;

case_t case_q [$];

task automatic add_case(input string name, input cube_src_e src, input pattern_e pat,
                        input move_t turn, input logic restart, input result_e kind,
                        input move_t bad);
    case_t c;
    c.name    = name;
    c.src     = src;
    c.pat     = pat;
    c.turn    = turn;
    c.restart = restart;
    c.kind    = kind;
    c.bad     = bad;
    case_q.push_back(c);
endtask

task automatic load_cases();
    add_case("null_list",    SRC_RANDOM,   PAT_NULL,   move_null, 1'b0, RES_SAME,    move_null);
    add_case("pair_r",       SRC_PREVIOUS, PAT_PAIR,   move_r,    1'b0, RES_SAME,    move_null);
    add_case("pair_ri",      SRC_RANDOM,   PAT_PAIR,   move_ri,   1'b0, RES_SAME,    move_null);
    add_case("pair_u",       SRC_PREVIOUS, PAT_PAIR,   move_u,    1'b0, RES_SAME,    move_null);
    add_case("pair_ui",      SRC_RANDOM,   PAT_PAIR,   move_ui,   1'b0, RES_SAME,    move_null);
    add_case("pair_f",       SRC_PREVIOUS, PAT_PAIR,   move_f,    1'b0, RES_SAME,    move_null);
    add_case("pair_fi",      SRC_RANDOM,   PAT_PAIR,   move_fi,   1'b0, RES_SAME,    move_null);
    add_case("pair_l",       SRC_PREVIOUS, PAT_PAIR,   move_l,    1'b0, RES_SAME,    move_null);
    add_case("pair_li",      SRC_RANDOM,   PAT_PAIR,   move_li,   1'b0, RES_SAME,    move_null);
    add_case("pair_b",       SRC_PREVIOUS, PAT_PAIR,   move_b,    1'b0, RES_SAME,    move_null);
    add_case("pair_bi",      SRC_RANDOM,   PAT_PAIR,   move_bi,   1'b0, RES_SAME,    move_null);
    add_case("pair_d",       SRC_PREVIOUS, PAT_PAIR,   move_d,    1'b0, RES_SAME,    move_null);
    add_case("pair_di",      SRC_RANDOM,   PAT_PAIR,   move_di,   1'b0, RES_SAME,    move_null);
    add_case("quad_r",       SRC_RANDOM,   PAT_QUAD,   move_r,    1'b0, RES_SAME,    move_null);
    add_case("quad_ui",      SRC_PREVIOUS, PAT_QUAD,   move_ui,   1'b0, RES_SAME,    move_null);
    add_case("quad_f",       SRC_RANDOM,   PAT_QUAD,   move_f,    1'b0, RES_SAME,    move_null);
    add_case("quad_li",      SRC_PREVIOUS, PAT_QUAD,   move_li,   1'b0, RES_SAME,    move_null);
    add_case("quad_b",       SRC_RANDOM,   PAT_QUAD,   move_b,    1'b0, RES_SAME,    move_null);
    add_case("quad_di",      SRC_PREVIOUS, PAT_QUAD,   move_di,   1'b0, RES_SAME,    move_null);
    add_case("random_a",     SRC_RANDOM,   PAT_RANDOM, move_null, 1'b0, RES_SAME,    move_null);
    add_case("random_b",     SRC_PREVIOUS, PAT_RANDOM, move_null, 1'b0, RES_SAME,    move_null);
    add_case("random_c",     SRC_RANDOM,   PAT_RANDOM, move_null, 1'b0, RES_SAME,    move_null);
    add_case("busy_restart", SRC_RANDOM,   PAT_PAIR,   move_f,    1'b1, RES_SAME,    move_null);
    add_case("recolor_u",    SRC_RECOLOR,  PAT_PAIR,   move_u,    1'b0, RES_ILLEGAL, move_u);
    add_case("recolor_bi",   SRC_RECOLOR,  PAT_QUAD,   move_bi,   1'b0, RES_ILLEGAL, move_bi);
    add_case("bad_code",     SRC_BAD_CODE, PAT_NULL,   move_null, 1'b0, RES_ILLEGAL, move_null);
    add_case("legal_again",  SRC_RANDOM,   PAT_QUAD,   move_d,    1'b0, RES_SAME,    move_null);
endtask

/* sim/cube_update_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cube_config.svh"

module cube_update_tb
    import cube_pkg::*;
();

    localparam int CYCLES_PER_CASE = 3000;
    localparam int RESET_CYCLES    = 16;
    localparam int SLOTS           = `CUBE_MOVE_SLOTS;
    localparam int HALF            = SLOTS / 2;

    logic        clock;
    logic        rst;
    logic        start;
    move_list_t  moves_in;
    cube_state_u cube_in;
    logic        busy;
    logic        done;
    logic        illegal;
    move_t       bad_move;
    cube_state_u cube_out;

    int          seed   = 32'h95ad;
    int          errors = 0;
    int          checks = 0;
    cube_state_u prev_cube;

    `include "cube_tb_cases.svh"

    cube_update u_dut (
        .clock    (clock),
        .rst      (rst),
        .start    (start),
        .moves_in (moves_in),
        .cube_in  (cube_in),
        .busy     (busy),
        .done     (done),
        .illegal  (illegal),
        .bad_move (bad_move),
        .cube_out (cube_out)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic int random_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic move_t random_code();
        logic [31:0] r;
        r = $random(seed);
        return move_t'(r[3:0]);
    endfunction

    // plain turns are even and each primed turn follows its plain turn
    function automatic move_t inverse_of(input move_t m);
        logic [3:0] code;
        code = m;
        if (code >= 4'd2 && code <= 4'd13) begin
            code = code ^ 4'd1;
        end
        return move_t'(code);
    endfunction

    // nine of each colour, then a shuffle
    function automatic cube_state_u random_legal_cube();
        cube_state_u c;
        color_t      tmp;
        int          j;
        for (int i = 0; i < `CUBE_STICKERS; i++) begin
            c.stickers[i] = color_t'(i / `CUBE_COLOR_QUOTA);
        end
        for (int i = `CUBE_STICKERS - 1; i > 0; i--) begin
            j = random_below(i + 1);
            tmp = c.stickers[i];
            c.stickers[i] = c.stickers[j];
            c.stickers[j] = tmp;
        end
        return c;
    endfunction

    function automatic cube_state_u make_cube(input cube_src_e src);
        cube_state_u c;
        int          idx;
        logic [2:0]  code;
        case (src)
            SRC_PREVIOUS: c = prev_cube;
            SRC_RECOLOR: begin
                c = random_legal_cube();
                idx = random_below(`CUBE_STICKERS);
                // move to one of the five other colours
                code = 3'((int'(c.stickers[idx]) + 1 + random_below(5)) % 6);
                c.stickers[idx] = color_t'(code);
            end
            SRC_BAD_CODE: begin
                c = random_legal_cube();
                idx = random_below(`CUBE_STICKERS);
                c.stickers[idx] = color_t'(3'd7);
            end
            default: c = random_legal_cube();
        endcase
        return c;
    endfunction

    function automatic move_list_t make_moves(input pattern_e pat, input move_t turn);
        move_list_t m;
        for (int i = 0; i < SLOTS; i++) begin
            m[i] = move_null;
        end
        case (pat)
            PAT_PAIR: begin
                m[0] = turn;
                m[1] = inverse_of(turn);
            end
            PAT_QUAD: begin
                for (int i = 0; i < 4; i++) begin
                    m[i] = turn;
                end
            end
            PAT_RANDOM: begin
                // unknown codes are mixed in and undo themselves
                for (int i = 0; i < HALF; i++) begin
                    m[i] = random_code();
                end
                for (int i = HALF; i < SLOTS; i++) begin
                    m[i] = inverse_of(m[SLOTS - 1 - i]);
                end
            end
            default: ;
        endcase
        return m;
    endfunction

    function automatic int count_color(input cube_state_u c, input int code);
        int n;
        n = 0;
        for (int i = 0; i < `CUBE_STICKERS; i++) begin
            if (int'(c.stickers[i]) == code) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_cube(input string name, input cube_state_u exp_cube,
                              input cube_state_u act_cube);
        checks++;
        if (act_cube.flat !== exp_cube.flat) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp_cube.flat, act_cube.flat);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_flag, input logic act_flag);
        checks++;
        if (act_flag !== exp_flag) begin
            errors++;
            $display("MISMATCH %s: expected %b, actual %b", name, exp_flag, act_flag);
        end
    endtask

    task automatic check_move(input string name, input move_t exp_move, input move_t act_move);
        checks++;
        if (act_move !== exp_move) begin
            errors++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp_move, act_move);
        end
    endtask

    task automatic check_count(input string name, input int exp_cnt, input int act_cnt);
        checks++;
        if (act_cnt != exp_cnt) begin
            errors++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp_cnt, act_cnt);
        end
    endtask

    task automatic pulse_start(input cube_state_u c, input move_list_t m);
        @(posedge clock);
        #2;
        cube_in  = c;
        moves_in = m;
        start    = 1'b1;
        @(posedge clock);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_for_done(output logic got);
        got = 1'b0;
        for (int n = 0; n < CYCLES_PER_CASE && !got; n++) begin
            @(negedge clock);
            got = done;
        end
    endtask

    task automatic run_case(input case_t tc);
        cube_state_u src_cube;
        move_list_t  moves;
        logic        got;
        src_cube = make_cube(tc.src);
        moves    = make_moves(tc.pat, tc.turn);
        pulse_start(src_cube, moves);
        @(negedge clock);
        check_flag({tc.name, " busy"}, 1'b1, busy);
        if (tc.restart) begin
            // a second sequence offered mid-run must be dropped
            repeat (100) @(posedge clock);
            pulse_start(make_cube(SRC_RECOLOR), make_moves(PAT_QUAD, move_u));
            @(negedge clock);
            check_flag({tc.name, " still busy"}, 1'b1, busy);
        end
        wait_for_done(got);
        if (!got) begin
            errors++;
            $display("case %s: no done pulse within %0d cycles", tc.name, CYCLES_PER_CASE);
        end else begin
            check_cube({tc.name, " cube_out"}, src_cube, cube_out);
            check_flag({tc.name, " illegal"}, tc.kind == RES_ILLEGAL, illegal);
            check_move({tc.name, " bad_move"}, tc.bad, bad_move);
            for (int k = 0; k < 8; k++) begin
                check_count({tc.name, " colour count"}, count_color(src_cube, k),
                            count_color(cube_out, k));
            end
            prev_cube = cube_out;
            @(negedge clock);
            check_flag({tc.name, " done pulse"}, 1'b0, done);
        end
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        cube_in.flat = '0;
        moves_in     = make_moves(PAT_NULL, move_null);
        prev_cube    = random_legal_cube();
        load_cases();
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        rst = 1'b0;
        foreach (case_q[i]) begin
            run_case(case_q[i]);
        end
        repeat (4) @(posedge clock);
        $display("cases %0d, checks %0d, errors %0d", case_q.size(), checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // each case needs about 2800 cycles
    initial begin
        int limit;
        #1;
        limit = case_q.size() * CYCLES_PER_CASE + RESET_CYCLES;
        repeat (limit) @(posedge clock);
        $display("watchdog expired: run did not finish within %0d cycles", limit);
        $display("cases %0d, checks %0d, errors %0d", case_q.size(), checks, errors);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
+incdir+sim
logic/cube_pkg.sv
logic/cube_turn.sv
logic/move_sequencer.sv
logic/color_census.sv
logic/cube_update.sv
sim/cube_update_tb.sv
